// ==== include/redmule_params.svh ====
`ifndef REDMULE_PARAMS_SVH
`define REDMULE_PARAMS_SVH

// Tile geometry
// WIDTH is the number of X rows per tile and the number of W and Z columns
`define REDMULE_ARRAY_WIDTH 4

// HEIGHT is the inner dimension K, so the columns of X and the rows of W
`define REDMULE_ARRAY_HEIGHT 4

// Operand elements are unsigned integers
`define REDMULE_ELEM_W 16

// Accumulators and bias elements
// Results wrap modulo 2^ACC_W
`define REDMULE_ACC_W 32

`endif

// ==== src/redmule_pkg.sv ====
`default_nettype none

`include "redmule_params.svh"

package redmule_pkg;

  // Scalar types
  typedef logic [`REDMULE_ELEM_W-1:0] elem_t;
  typedef logic [`REDMULE_ACC_W-1:0]  acc_t;

  // One beat on each stream
  typedef elem_t [`REDMULE_ARRAY_HEIGHT-1:0] x_row_t;
  typedef elem_t [`REDMULE_ARRAY_WIDTH-1:0]  w_row_t;
  typedef acc_t  [`REDMULE_ARRAY_WIDTH-1:0]  acc_row_t;

  // Whole operand matrices of one tile
  typedef x_row_t [`REDMULE_ARRAY_WIDTH-1:0]  x_mat_t;
  typedef w_row_t [`REDMULE_ARRAY_HEIGHT-1:0] w_mat_t;

  // Buffer contents handed to the engine
  typedef struct packed {
    logic   full;
    x_mat_t rows;
  } x_tile_t;

  typedef struct packed {
    logic   full;
    w_mat_t rows;
  } w_tile_t;

  typedef enum logic {IDLE, ISSUE} engine_state_e;

endpackage

`default_nettype wire

// ==== src/redmule_x_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "redmule_params.svh"

module redmule_x_buffer
  import redmule_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // X row stream
  input  logic    x_valid_i,
  output logic    x_ready_o,
  input  x_row_t  x_data_i,
  // Engine side
  input  logic    tile_release_i,
  output x_tile_t x_tile_o
);

  localparam int unsigned ROWS  = `REDMULE_ARRAY_WIDTH;
  localparam int unsigned ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;

  logic [ROW_W-1:0] cnt_q;
  logic             full_q;
  logic             load;
  logic             last_row;
  x_mat_t           rows_q;

  // Accept rows only while the tile is still being filled
  assign x_ready_o = ~full_q;
  assign load      = x_valid_i & x_ready_o;
  assign last_row  = (cnt_q == ROW_W'(ROWS - 1));

  // Control state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (load) begin
        if (last_row) begin
          cnt_q  <= '0;
          full_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + ROW_W'(1);
        end
      end
      // Engine has taken the last row into its pipeline
      if (tile_release_i) begin
        full_q <= 1'b0;
      end
    end
  end

  // Row storage, written in arrival order
  always_ff @(posedge clk_i) begin
    if (load) begin
      rows_q[cnt_q] <= x_data_i;
    end
  end

  assign x_tile_o.full = full_q;
  assign x_tile_o.rows = rows_q;

  // The engine may only release a tile it was allowed to read
  a_release_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tile_release_i |-> full_q
  ) else $error("X buffer released while not full");

endmodule

`default_nettype wire

// ==== src/redmule_w_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "redmule_params.svh"

module redmule_w_buffer
  import redmule_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  // W row stream
  input  logic    w_valid_i,
  output logic    w_ready_o,
  input  w_row_t  w_data_i,
  // Engine side
  input  logic    tile_release_i,
  output w_tile_t w_tile_o
);

  // W holds K rows, one per inner-dimension index
  localparam int unsigned ROWS  = `REDMULE_ARRAY_HEIGHT;
  localparam int unsigned ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;

  logic [ROW_W-1:0] cnt_q;
  logic             full_q;
  logic             load;
  logic             last_row;
  w_mat_t           rows_q;

  assign w_ready_o = ~full_q;
  assign load      = w_valid_i & w_ready_o;
  assign last_row  = (cnt_q == ROW_W'(ROWS - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else begin
      if (load) begin
        if (last_row) begin
          cnt_q  <= '0;
          full_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + ROW_W'(1);
        end
      end
      // Refill may start right after the release
      if (tile_release_i) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rows_q[cnt_q] <= w_data_i;
    end
  end

  assign w_tile_o.full = full_q;
  assign w_tile_o.rows = rows_q;

  a_release_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tile_release_i |-> full_q
  ) else $error("W buffer released while not full");

endmodule

`default_nettype wire

// ==== src/redmule_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "redmule_params.svh"

module redmule_engine
  import redmule_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Operand tiles from the buffers
  input  x_tile_t  x_tile_i,
  input  w_tile_t  w_tile_i,
  // Bias rows
  input  logic     y_valid_i,
  output logic     y_ready_o,
  input  acc_row_t y_data_i,
  // Result rows
  output logic     z_valid_o,
  input  logic     z_ready_i,
  output acc_row_t z_data_o,
  // One pulse per tile on the last row issue
  output logic     tile_release_o
);

  localparam int unsigned WIDTH  = `REDMULE_ARRAY_WIDTH;
  localparam int unsigned HEIGHT = `REDMULE_ARRAY_HEIGHT;
  localparam int unsigned ROW_W  = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  engine_state_e state_q;
  logic [ROW_W-1:0] row_q;
  logic [ROW_W-1:0] issue_row;
  logic             tiles_rdy;
  logic             last_issue;
  logic             issue;
  x_row_t           x_sel;

  // Stage 1 holds products indexed [column n][inner k]
  acc_t [WIDTH-1:0][HEIGHT-1:0] prod_d;
  acc_t [WIDTH-1:0][HEIGHT-1:0] s1_prod_q;
  acc_row_t                     s1_bias_q;
  logic                         s1_valid_q;
  logic                         s1_free;

  // Stage 2 is the output register
  acc_row_t sum_d;
  acc_row_t s2_sum_q;
  logic     s2_valid_q;
  logic     s2_ready;

  // Handshake between the stages
  assign s2_ready = ~s2_valid_q | z_ready_i;
  assign s1_free  = ~s1_valid_q | s2_ready;

  assign tiles_rdy = x_tile_i.full & w_tile_i.full;
  assign y_ready_o = tiles_rdy & s1_free;
  assign issue     = y_valid_i & y_ready_o;

  // A fresh tile always starts at row 0
  assign issue_row      = (state_q == IDLE) ? '0 : row_q;
  assign last_issue     = (issue_row == ROW_W'(WIDTH - 1));
  assign tile_release_o = issue & last_issue;

  // Row index is only meaningful while in ISSUE
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      row_q   <= '0;
    end else if (issue) begin
      if (last_issue) begin
        state_q <= IDLE;
      end else begin
        state_q <= ISSUE;
        row_q   <= issue_row + ROW_W'(1);
      end
    end
  end

  // Products of the selected X row with every W column
  assign x_sel = x_tile_i.rows[issue_row];

  always_comb begin
    for (int n = 0; n < WIDTH; n++) begin
      for (int k = 0; k < HEIGHT; k++) begin
        prod_d[n][k] = acc_t'(x_sel[k]) * acc_t'(w_tile_i.rows[k][n]);
      end
    end
  end

  // Bias plus the column sums wraps at the accumulator width
  always_comb begin
    for (int n = 0; n < WIDTH; n++) begin
      sum_d[n] = s1_bias_q[n];
      for (int k = 0; k < HEIGHT; k++) begin
        sum_d[n] = sum_d[n] + s1_prod_q[n][k];
      end
    end
  end

  // Valid bits
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_free) begin
        s1_valid_q <= issue;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  // Payload follows its valid bit
  always_ff @(posedge clk_i) begin
    if (issue) begin
      s1_prod_q <= prod_d;
      s1_bias_q <= y_data_i;
    end
    if (s1_valid_q && s2_ready) begin
      s2_sum_q <= sum_d;
    end
  end

  assign z_valid_o = s2_valid_q;
  assign z_data_o  = s2_sum_q;

  // A stalled result must not change under the consumer
  a_z_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (z_valid_o && !z_ready_i) |=> (z_valid_o && $stable(z_data_o))
  ) else $error("Z row changed while stalled");

  // Buffers need one cycle to drop full before another release
  a_release_single: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    tile_release_o |=> !tile_release_o
  ) else $error("Tile release held for two cycles");

endmodule

`default_nettype wire

// ==== src/redmule_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "redmule_params.svh"

module redmule_top
  import redmule_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // X operand rows
  input  logic     x_valid_i,
  output logic     x_ready_o,
  input  x_row_t   x_data_i,
  // W operand rows
  input  logic     w_valid_i,
  output logic     w_ready_o,
  input  w_row_t   w_data_i,
  // Y bias rows
  input  logic     y_valid_i,
  output logic     y_ready_o,
  input  acc_row_t y_data_i,
  // Z result rows
  output logic     z_valid_o,
  input  logic     z_ready_i,
  output acc_row_t z_data_o
);

  x_tile_t x_tile;
  w_tile_t w_tile;
  logic    tile_release;

  // Both operand buffers fill in parallel
  redmule_x_buffer i_x_buffer (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .x_valid_i      ( x_valid_i    ),
    .x_ready_o      ( x_ready_o    ),
    .x_data_i       ( x_data_i     ),
    .tile_release_i ( tile_release ),
    .x_tile_o       ( x_tile       )
  );

  redmule_w_buffer i_w_buffer (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .w_valid_i      ( w_valid_i    ),
    .w_ready_o      ( w_ready_o    ),
    .w_data_i       ( w_data_i     ),
    .tile_release_i ( tile_release ),
    .w_tile_o       ( w_tile       )
  );

  // Engine consumes one bias row per output row
  redmule_engine i_engine (
    .clk_i          ( clk_i        ),
    .rst_n_i        ( rst_n_i      ),
    .x_tile_i       ( x_tile       ),
    .w_tile_i       ( w_tile       ),
    .y_valid_i      ( y_valid_i    ),
    .y_ready_o      ( y_ready_o    ),
    .y_data_i       ( y_data_i     ),
    .z_valid_o      ( z_valid_o    ),
    .z_ready_i      ( z_ready_i    ),
    .z_data_o       ( z_data_o     ),
    .tile_release_o ( tile_release )
  );

endmodule

`default_nettype wire

// ==== tests/tb_redmule_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "redmule_params.svh"

module tb_redmule_top
  import redmule_pkg::*;
();

  localparam int WIDTH      = `REDMULE_ARRAY_WIDTH;
  localparam int HEIGHT     = `REDMULE_ARRAY_HEIGHT;
  localparam int MAX_TILES  = 3;
  // Word offsets of the four row groups inside one tile of the pattern file
  localparam int X_OFS      = 0;
  localparam int W_OFS      = WIDTH * HEIGHT;
  localparam int Y_OFS      = 2 * WIDTH * HEIGHT;
  localparam int Z_OFS      = Y_OFS + WIDTH * WIDTH;
  localparam int TILE_WORDS = Z_OFS + WIDTH * WIDTH;
  localparam int DEPTH      = 1 + MAX_TILES * TILE_WORDS;
  localparam int WAIT_LIMIT = 200;
  localparam logic [31:0] SEED      = 32'h0817_80da;
  localparam logic [31:0] ELEM_MASK = 32'h0000_ffff;

  logic     clk_i;
  logic     rst_n_i;
  logic     x_valid_i;
  logic     x_ready_o;
  x_row_t   x_data_i;
  logic     w_valid_i;
  logic     w_ready_o;
  w_row_t   w_data_i;
  logic     y_valid_i;
  logic     y_ready_o;
  acc_row_t y_data_i;
  logic     z_valid_o;
  logic     z_ready_i;
  acc_row_t z_data_o;

  logic [31:0] pat [DEPTH];
  // One generator state per stream: X, W, Y and Z ready
  logic [31:0] rng [4];
  int ntiles;
  int num_checks;
  int num_errors;
  int num_failures;

  redmule_top DUT (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .x_valid_i ( x_valid_i ),
    .x_ready_o ( x_ready_o ),
    .x_data_i  ( x_data_i  ),
    .w_valid_i ( w_valid_i ),
    .w_ready_o ( w_ready_o ),
    .w_data_i  ( w_data_i  ),
    .y_valid_i ( y_valid_i ),
    .y_ready_o ( y_ready_o ),
    .y_data_i  ( y_data_i  ),
    .z_valid_o ( z_valid_o ),
    .z_ready_i ( z_ready_i ),
    .z_data_o  ( z_data_o  )
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] word(input int t, input int ofs, input int cols,
                                       input int r, input int c);
    return pat[1 + t * TILE_WORDS + ofs + r * cols + c];
  endfunction

  // Z[r][n] = Y[r][n] + sum over k of X[r][k] * W[k][n], wrapping at 32 bits
  function automatic acc_t expected_elem(input int t, input int r, input int n);
    acc_t acc;
    acc_t xv;
    acc_t wv;
    acc = word(t, Y_OFS, WIDTH, r, n);
    for (int k = 0; k < HEIGHT; k++) begin
      xv  = word(t, X_OFS, HEIGHT, r, k) & ELEM_MASK;
      wv  = word(t, W_OFS, WIDTH, k, n) & ELEM_MASK;
      acc = acc + xv * wv;
    end
    return acc;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("Mismatch at %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic stream_ready(input int id);
    case (id)
      0:       return x_ready_o;
      1:       return w_ready_o;
      default: return y_ready_o;
    endcase
  endfunction

  task automatic set_valid(input int id, input logic v);
    case (id)
      0:       x_valid_i = v;
      1:       w_valid_i = v;
      default: y_valid_i = v;
    endcase
  endtask

  task automatic load_row(input int id, input int t, input int r);
    if (id == 0) begin
      for (int k = 0; k < HEIGHT; k++) x_data_i[k] = elem_t'(word(t, X_OFS, HEIGHT, r, k));
    end else if (id == 1) begin
      for (int n = 0; n < WIDTH; n++) w_data_i[n] = elem_t'(word(t, W_OFS, WIDTH, r, n));
    end else begin
      for (int n = 0; n < WIDTH; n++) y_data_i[n] = word(t, Y_OFS, WIDTH, r, n);
    end
  endtask

  // Sends all rows of one input stream, optionally with idle gaps between beats
  task automatic send_stream(input int id, input int tiles, input bit gaps);
    int  rows;
    int  waited;
    bit  done;
    rows = (id == 1) ? HEIGHT : WIDTH;
    for (int t = 0; t < tiles; t++) begin
      for (int r = 0; r < rows; r++) begin
        if (gaps) begin
          rng[id] = xorshift32(rng[id]);
          while (rng[id][1:0] == 2'b00) begin
            set_valid(id, 1'b0);
            @(posedge clk_i);
            #0.5;
            rng[id] = xorshift32(rng[id]);
          end
        end
        load_row(id, t, r);
        set_valid(id, 1'b1);
        waited = 0;
        done   = 1'b0;
        while (!done && waited < WAIT_LIMIT) begin
          @(posedge clk_i);
          done = stream_ready(id);
          waited++;
        end
        if (!done) begin
          num_failures++;
          $display("Timeout at %0t: stream %0d row %0d of tile %0d was never accepted",
                   $time, id, r, t);
        end
        #0.5;
      end
    end
    set_valid(id, 1'b0);
  endtask

  // Drives z_ready_i and checks every Z beat, the stall rule and the tile overlap
  task automatic watch_outputs(input int tiles, input bit stalls, input bit timed);
    int       cyc;
    int       idle;
    int       z_seen;
    int       y_seen;
    int       zt;
    int       zr;
    int       y_cyc [$];
    bit       held_valid;
    bit       armed;
    bit       reopened;
    acc_row_t held;
    cyc = 0;
    idle = 0;
    z_seen = 0;
    y_seen = 0;
    held_valid = 1'b0;
    armed = 1'b0;
    reopened = 1'b0;
    held = '0;
    z_ready_i = 1'b1;
    while (z_seen < WIDTH * tiles && idle < WAIT_LIMIT) begin
      @(posedge clk_i);
      cyc++;
      idle++;
      if (held_valid) begin
        check_value(32'(z_valid_o), 32'd1, "z_valid_o dropped while stalled");
        for (int n = 0; n < WIDTH; n++) check_value(z_data_o[n], held[n], "stalled z_data_o");
      end
      held_valid = z_valid_o & ~z_ready_i;
      held       = z_data_o;
      if (z_valid_o && z_ready_i) begin
        zt = z_seen / WIDTH;
        zr = z_seen % WIDTH;
        for (int n = 0; n < WIDTH; n++) begin
          check_value(z_data_o[n], expected_elem(zt, zr, n),
                      $sformatf("tile %0d Z row %0d element %0d", zt, zr, n));
        end
        if (y_cyc.size() == 0) begin
          num_failures++;
          $display("Z row %0d of tile %0d came out with no bias row taken for it", zr, zt);
        end else if (timed) begin
          check_value(cyc - y_cyc.pop_front(), 32'd2, "cycles from Y transfer to Z");
        end else begin
          void'(y_cyc.pop_front());
        end
        // Next tile must already be loading while this one drains
        if (zr == WIDTH - 1) check_value(32'(reopened), 32'd1, "x_ready_o before last Z row");
        z_seen++;
        idle = 0;
      end
      if (armed && x_ready_o) reopened = 1'b1;
      if (y_valid_i && y_ready_o) begin
        y_cyc.push_back(cyc);
        y_seen++;
        if (y_seen % WIDTH == 0) begin
          armed    = 1'b1;
          reopened = 1'b0;
        end
      end
      #0.5;
      rng[3]    = xorshift32(rng[3]);
      z_ready_i = stalls ? (rng[3][2:0] > 3'd2) : 1'b1;
    end
    if (idle >= WAIT_LIMIT) begin
      num_failures++;
      $display("Timeout at %0t: Z rows stopped after %0d of %0d", $time, z_seen, WIDTH * tiles);
    end
    check_value(z_seen, WIDTH * tiles, "number of Z beats");
    z_ready_i = 1'b1;
    repeat (2 * WIDTH) begin
      @(posedge clk_i);
      check_value(32'(z_valid_o), 32'd0, "z_valid_o after the last row");
    end
    #0.5;
  endtask

  initial begin
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    x_valid_i = 1'b0;
    w_valid_i = 1'b0;
    y_valid_i = 1'b0;
    z_ready_i = 1'b0;
    x_data_i = '0;
    w_data_i = '0;
    y_data_i = '0;
    num_checks = 0;
    num_errors = 0;
    num_failures = 0;
    rng[0] = SEED;
    for (int i = 1; i < 4; i++) rng[i] = xorshift32(rng[i-1]);
    $readmemh("tests/redmule_patterns.hex", pat);
    ntiles = int'(pat[0]);
    if ($isunknown(pat[0]) || ntiles < 1 || ntiles > MAX_TILES) begin
      num_failures++;
      $display("The pattern file could not be read or has a bad tile count");
    end else begin
      // The file's expected rows must follow the product-plus-bias rule
      for (int t = 0; t < ntiles; t++) begin
        for (int r = 0; r < WIDTH; r++) begin
          for (int n = 0; n < WIDTH; n++) begin
            check_value(word(t, Z_OFS, WIDTH, r, n), expected_elem(t, r, n),
                        $sformatf("pattern file tile %0d Z row %0d element %0d", t, r, n));
          end
        end
      end
      repeat (16) @(posedge clk_i);
      #0.5;
      rst_n_i = 1'b1;
      @(posedge clk_i);
      check_value(32'(z_valid_o), 32'd0, "z_valid_o after reset");
      check_value(32'(y_ready_o), 32'd0, "y_ready_o after reset");
      check_value(32'(x_ready_o), 32'd1, "x_ready_o after reset");
      check_value(32'(w_ready_o), 32'd1, "w_ready_o after reset");
      #0.5;
      // Back-to-back traffic with exact latency
      fork
        send_stream(0, ntiles, 1'b0);
        send_stream(1, ntiles, 1'b0);
        send_stream(2, ntiles, 1'b0);
        watch_outputs(ntiles, 1'b0, 1'b1);
      join
      // Random input gaps and output back-pressure
      fork
        send_stream(0, ntiles, 1'b1);
        send_stream(1, ntiles, 1'b1);
        send_stream(2, ntiles, 1'b1);
        watch_outputs(ntiles, 1'b1, 1'b0);
      join
    end
    $display("Checks: %0d, mismatches: %0d, other failures: %0d",
             num_checks, num_errors, num_failures);
    if (num_errors == 0 && num_failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/redmule_patterns.hex ====
// Word 0 is the tile count, then per tile one row per line, element 0 first:
// 4 X rows, 4 W rows, 4 Y bias rows, 4 expected Z rows (Z = Y + X*W mod 2^32)
3
// Tile 0 has W as the identity
0001 0002 0003 0004
0005 0006 0007 0008
0009 000a 000b 000c
000d 000e 000f 0010
0001 0000 0000 0000
0000 0001 0000 0000
0000 0000 0001 0000
0000 0000 0000 0001
00000100 00000200 00000300 00000400
00001000 00002000 00003000 00004000
00000000 00000000 00000000 00000000
00000010 00000020 00000030 00000040
00000101 00000202 00000303 00000404
00001005 00002006 00003007 00004008
00000009 0000000a 0000000b 0000000c
0000001d 0000002e 0000003f 00000050
// Tile 1 has small integer products
0001 0001 0001 0001
0001 0002 0003 0004
0002 0000 0000 0000
0000 0000 0000 0003
0001 0002 0003 0004
0005 0006 0007 0008
0009 000a 000b 000c
000d 000e 000f 0010
00000000 00000000 00000000 00000000
00000001 00000001 00000001 00000001
ffffff00 00000000 00000000 00000000
00000100 00000100 00000100 00000100
0000001c 00000020 00000024 00000028
0000005b 00000065 0000006f 00000079
ffffff02 00000004 00000006 00000008
00000127 0000012a 0000012d 00000130
// Tile 2 wraps the accumulator
ffff ffff ffff ffff
ffff ffff ffff ffff
ffff ffff ffff ffff
ffff ffff ffff ffff
ffff ffff ffff ffff
ffff ffff ffff ffff
ffff ffff ffff ffff
ffff ffff ffff ffff
00000000 00000000 00000000 00000000
0007fffc 0007fffc 0007fffc 0007fffc
ffffffff 80000000 12345678 0007fffc
80000000 80000000 80000000 80000000
fff80004 fff80004 fff80004 fff80004
00000000 00000000 00000000 00000000
fff80003 7ff80004 122c567c 00000000
7ff80004 7ff80004 7ff80004 7ff80004

// ==== list.f ====
+incdir+include
src/redmule_pkg.sv
src/redmule_x_buffer.sv
src/redmule_w_buffer.sv
src/redmule_engine.sv
src/redmule_top.sv
tests/tb_redmule_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_redmule_top -f list.f -Mdir obj_dir || exit 1
out=$(./obj_dir/Vtb_redmule_top 2>&1)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
